// ==== card_config.svh ====
// card geometry and widths where the whole card must fit the counter range and the glyph box lies inside the border

`ifndef CARD_CONFIG_SVH
`define CARD_CONFIG_SVH

// ----------------------------------------------------------------------
// card placement
// ----------------------------------------------------------------------
`define CARD_XPOS 20    // left edge
`define CARD_YPOS 30    // top edge
`define CARD_W    56    // right edge at xpos + w, inclusive
`define CARD_H    80    // bottom edge at ypos + h, inclusive

// ----------------------------------------------------------------------
// rank glyph box
// ----------------------------------------------------------------------
`define GLYPH_DX  5     // offset from card corner
`define GLYPH_DY  5
`define GLYPH_W   8
`define GLYPH_H   9

// ----------------------------------------------------------------------
// widths and pipeline
// ----------------------------------------------------------------------
`define COORD_W   11    // pixel counters
`define RGB_W     12    // 4:4:4 colour

`define CLASSIFY_STAGES 2   // classifier depth seen by the delay line

`endif

// ==== card_pkg.sv ====
// shared types sized from card_config.svh and rank values 0, 14 and 15 mean no card

`include "card_config.svh"

package card_pkg;

    typedef logic [`COORD_W-1:0] coord_t;
    typedef logic [`RGB_W-1:0]   rgb_t;
    typedef logic [3:0]          card_value_t;   // rank 1..13

    typedef enum logic [1:0] {
        SUIT_SPADE   = 2'd0,
        SUIT_CLUB    = 2'd1,
        SUIT_HEART   = 2'd2,
        SUIT_DIAMOND = 2'd3
    } card_suit_t;

    // one rank bitmap with row 0 in the top bits and leftmost pixel as row msb
    typedef logic [`GLYPH_W*`GLYPH_H-1:0] glyph_t;

    // ----------------------------------------------------------------------
    // palette
    // ----------------------------------------------------------------------
    localparam rgb_t INK_BLACK    = 12'h000;
    localparam rgb_t INK_RED      = 12'hF00;
    localparam rgb_t FACE_WHITE   = 12'hFFF;
    localparam rgb_t BORDER_BLACK = 12'h000;

endpackage

// ==== vga_bus_if.sv ====
// plain level stream with no handshake and all seven signals sampled every clock

`timescale 1ns/1ps

interface vga_bus_if;

    card_pkg::coord_t hcount;
    card_pkg::coord_t vcount;
    logic             hsync;
    logic             vsync;
    logic             hblnk;
    logic             vblnk;
    card_pkg::rgb_t   rgb;

    modport source (
        output hcount,
        output vcount,
        output hsync,
        output vsync,
        output hblnk,
        output vblnk,
        output rgb
    );

    modport sink (
        input hcount,
        input vcount,
        input hsync,
        input vsync,
        input hblnk,
        input vblnk,
        input rgb
    );

endinterface

// ==== card_face_classifier.sv ====
// latency of two cycles and glyph bitmaps read from card_glyphs.mem for ranks 1 to 13 only

`timescale 1ns/1ps

`include "card_config.svh"

module card_face_classifier (
    input  logic                  clk,
    input  logic                  rst,
    vga_bus_if.sink               vga,
    input  card_pkg::card_value_t card_value,
    input  card_pkg::card_suit_t  card_suit,
    output logic                  overlay_hit,
    output card_pkg::rgb_t        overlay_rgb
);

    import card_pkg::*;

    localparam int RANKS      = 13;
    localparam int GLYPH_BITS = `GLYPH_W * `GLYPH_H;
    localparam int ROW_W      = $clog2(`GLYPH_H);
    localparam int COL_W      = $clog2(`GLYPH_W);
    localparam int IDX_W      = $clog2(GLYPH_BITS);

    glyph_t glyph_rom [1:RANKS];

    initial begin
        $readmemh("card_glyphs.mem", glyph_rom);
    end

    // ----------------------------------------------------------------------
    // stage 1 geometry from the raw counts
    // ----------------------------------------------------------------------
    coord_t h_off, v_off;   // offsets from glyph corner, wrap when left/above
    logic   in_rect, on_edge, in_glyph;

    assign h_off = vga.hcount - coord_t'(`CARD_XPOS + `GLYPH_DX);
    assign v_off = vga.vcount - coord_t'(`CARD_YPOS + `GLYPH_DY);

    assign in_rect  = (vga.hcount >= `CARD_XPOS) && (vga.hcount <= `CARD_XPOS + `CARD_W) &&
                      (vga.vcount >= `CARD_YPOS) && (vga.vcount <= `CARD_YPOS + `CARD_H);
    assign on_edge  = in_rect &&
                      ((vga.hcount == `CARD_XPOS) || (vga.hcount == `CARD_XPOS + `CARD_W) ||
                       (vga.vcount == `CARD_YPOS) || (vga.vcount == `CARD_YPOS + `CARD_H));
    assign in_glyph = (h_off < `GLYPH_W) && (v_off < `GLYPH_H);

    logic             in_rect_q, on_edge_q, in_glyph_q, valid_q;
    logic [ROW_W-1:0] glyph_row_q;
    logic [COL_W-1:0] glyph_col_q;
    card_value_t      value_q;
    rgb_t             ink_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_rect_q   <= 1'b0;
            on_edge_q   <= 1'b0;
            in_glyph_q  <= 1'b0;
            valid_q     <= 1'b0;
            glyph_row_q <= '0;
            glyph_col_q <= '0;
            value_q     <= '0;
            ink_q       <= '0;
        end else begin
            in_rect_q   <= in_rect;
            on_edge_q   <= on_edge;
            in_glyph_q  <= in_glyph;
            valid_q     <= !(card_value inside {4'd0, 4'd14, 4'd15});
            glyph_row_q <= v_off[ROW_W-1:0];
            glyph_col_q <= h_off[COL_W-1:0];
            value_q     <= card_value;
            ink_q       <= (card_suit inside {SUIT_HEART, SUIT_DIAMOND}) ? INK_RED : INK_BLACK;
        end
    end

    // ----------------------------------------------------------------------
    // stage 2 glyph lookup and colour pick
    // ----------------------------------------------------------------------
    glyph_t           glyph_bits;
    logic [IDX_W-1:0] bit_idx;
    logic             glyph_on;

    assign glyph_bits = valid_q ? glyph_rom[value_q] : '0;  // keep invalid ranks off the rom
    assign bit_idx    = IDX_W'(GLYPH_BITS - 1 - (int'(glyph_row_q) * `GLYPH_W + int'(glyph_col_q)));
    assign glyph_on   = in_glyph_q && glyph_bits[bit_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            overlay_hit <= 1'b0;
            overlay_rgb <= '0;
        end else begin
            overlay_hit <= in_rect_q && valid_q;
            if (on_edge_q)
                overlay_rgb <= BORDER_BLACK;
            else if (glyph_on)
                overlay_rgb <= ink_q;
            else
                overlay_rgb <= FACE_WHITE;
        end
    end

    // no card in stage 1 means no overlay one stage later
    a_no_hit_without_card: assert property (
        @(posedge clk) disable iff (rst)
        overlay_hit |-> !($past(value_q) inside {4'd0, 4'd14, 4'd15})
    ) else $error("overlay_hit set for an invalid card value");

endmodule

// ==== vga_delay_line.sv ====
// latency of `CLASSIFY_STAGES cycles which must be at least 1 and reset clears the whole stream

`timescale 1ns/1ps

`include "card_config.svh"

module vga_delay_line (
    input  logic      clk,
    input  logic      rst,
    vga_bus_if.sink   din,
    vga_bus_if.source dout
);

    import card_pkg::*;

    localparam int STAGES = `CLASSIFY_STAGES;

    coord_t hcount_q [STAGES];
    coord_t vcount_q [STAGES];
    logic   hsync_q  [STAGES];
    logic   vsync_q  [STAGES];
    logic   hblnk_q  [STAGES];
    logic   vblnk_q  [STAGES];
    rgb_t   rgb_q    [STAGES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                hcount_q[i] <= '0;
                vcount_q[i] <= '0;
                hsync_q[i]  <= 1'b0;
                vsync_q[i]  <= 1'b0;
                hblnk_q[i]  <= 1'b0;
                vblnk_q[i]  <= 1'b0;
                rgb_q[i]    <= '0;
            end
        end else begin
            hcount_q[0] <= din.hcount;
            vcount_q[0] <= din.vcount;
            hsync_q[0]  <= din.hsync;
            vsync_q[0]  <= din.vsync;
            hblnk_q[0]  <= din.hblnk;
            vblnk_q[0]  <= din.vblnk;
            rgb_q[0]    <= din.rgb;
            for (int i = 1; i < STAGES; i++) begin
                hcount_q[i] <= hcount_q[i-1];
                vcount_q[i] <= vcount_q[i-1];
                hsync_q[i]  <= hsync_q[i-1];
                vsync_q[i]  <= vsync_q[i-1];
                hblnk_q[i]  <= hblnk_q[i-1];
                vblnk_q[i]  <= vblnk_q[i-1];
                rgb_q[i]    <= rgb_q[i-1];
            end
        end
    end

    // oldest entry feeds the mixer
    assign dout.hcount = hcount_q[STAGES-1];
    assign dout.vcount = vcount_q[STAGES-1];
    assign dout.hsync  = hsync_q[STAGES-1];
    assign dout.vsync  = vsync_q[STAGES-1];
    assign dout.hblnk  = hblnk_q[STAGES-1];
    assign dout.vblnk  = vblnk_q[STAGES-1];
    assign dout.rgb    = rgb_q[STAGES-1];

endmodule

// ==== card_pixel_mixer.sv ====
// latency of one cycle and overlay_hit with overlay_rgb must line up with the incoming stream

`timescale 1ns/1ps

`include "card_config.svh"

module card_pixel_mixer (
    input  logic             clk,
    input  logic             rst,
    vga_bus_if.sink          vga,
    input  logic             overlay_hit,
    input  card_pkg::rgb_t   overlay_rgb,
    output card_pkg::coord_t hcount,
    output card_pkg::coord_t vcount,
    output logic             hsync,
    output logic             vsync,
    output logic             hblnk,
    output logic             vblnk,
    output card_pkg::rgb_t   rgb
);

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= '0;
        end else begin
            hcount <= vga.hcount;
            vcount <= vga.vcount;
            hsync  <= vga.hsync;
            vsync  <= vga.vsync;
            hblnk  <= vga.hblnk;
            vblnk  <= vga.vblnk;
            if (vga.hblnk || vga.vblnk)
                rgb <= '0;             // blanking wins over the card
            else if (overlay_hit)
                rgb <= overlay_rgb;
            else
                rgb <= vga.rgb;        // pass-through
        end
    end

    // a card hit must belong to the delayed pixel it is merged with
    a_hit_inside_card: assert property (
        @(posedge clk) disable iff (rst)
        overlay_hit |-> (vga.hcount >= `CARD_XPOS) && (vga.hcount <= `CARD_XPOS + `CARD_W) &&
                        (vga.vcount >= `CARD_YPOS) && (vga.vcount <= `CARD_YPOS + `CARD_H)
    ) else $error("overlay_hit set for a pixel outside the card");

endmodule

// ==== card_overlay_top.sv ====
// every output is the input from three clocks back and card_value with card_suit is sampled with the counts

`timescale 1ns/1ps

module card_overlay_top (
    input  logic                  clk,
    input  logic                  rst,
    input  card_pkg::coord_t      hcount_in,
    input  card_pkg::coord_t      vcount_in,
    input  logic                  hsync_in,
    input  logic                  vsync_in,
    input  logic                  hblnk_in,
    input  logic                  vblnk_in,
    input  card_pkg::rgb_t        rgb_in,
    input  card_pkg::card_value_t card_value,
    input  card_pkg::card_suit_t  card_suit,
    output card_pkg::coord_t      hcount_out,
    output card_pkg::coord_t      vcount_out,
    output logic                  hsync_out,
    output logic                  vsync_out,
    output logic                  hblnk_out,
    output logic                  vblnk_out,
    output card_pkg::rgb_t        rgb_out
);

    vga_bus_if vga_in_bus ();
    vga_bus_if vga_dly_bus ();

    logic           overlay_hit;
    card_pkg::rgb_t overlay_rgb;

    // ----------------------------------------------------------------------
    // input stream onto the bus
    // ----------------------------------------------------------------------
    assign vga_in_bus.hcount = hcount_in;
    assign vga_in_bus.vcount = vcount_in;
    assign vga_in_bus.hsync  = hsync_in;
    assign vga_in_bus.vsync  = vsync_in;
    assign vga_in_bus.hblnk  = hblnk_in;
    assign vga_in_bus.vblnk  = vblnk_in;
    assign vga_in_bus.rgb    = rgb_in;

    card_face_classifier u_classifier (
        .clk,
        .rst,
        .vga         (vga_in_bus.sink),
        .card_value,
        .card_suit,
        .overlay_hit,
        .overlay_rgb
    );

    vga_delay_line u_delay (
        .clk,
        .rst,
        .din  (vga_in_bus.sink),
        .dout (vga_dly_bus.source)
    );

    card_pixel_mixer u_mixer (
        .clk,
        .rst,
        .vga         (vga_dly_bus.sink),
        .overlay_hit,
        .overlay_rgb,
        .hcount      (hcount_out),
        .vcount      (vcount_out),
        .hsync       (hsync_out),
        .vsync       (vsync_out),
        .hblnk       (hblnk_out),
        .vblnk       (vblnk_out),
        .rgb         (rgb_out)
    );

endmodule

// ==== tb_clock_gen.sv ====
// free running clock from time zero and reset released a fixed 10 ns after a rising edge

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rst = 1'b0;    // same drive delay as the stimulus
    end

endmodule

// ==== tb_card_overlay.sv ====
// self-checking testbench for card_overlay_top that must run from the project root to find card_glyphs.mem

`timescale 1ns/1ps

`include "card_config.svh"

module tb_card_overlay;

    import card_pkg::*;

    localparam int N_STIM         = 3000;
    localparam int SEGMENT        = 64;    // cycles per card
    localparam int LATENCY        = 3;
    localparam int TIMEOUT_CYCLES = N_STIM + 20;

    // expected pixel kinds
    localparam logic [2:0] K_PASS   = 3'd0;
    localparam logic [2:0] K_BORDER = 3'd1;
    localparam logic [2:0] K_FACE   = 3'd2;
    localparam logic [2:0] K_INK    = 3'd3;
    localparam logic [2:0] K_BLANK  = 3'd4;

    typedef struct packed {
        coord_t     hcount;
        coord_t     vcount;
        logic       hsync;
        logic       vsync;
        logic       hblnk;
        logic       vblnk;
        rgb_t       rgb;
        logic [2:0] kind;
    } expect_t;

    logic        clk;
    logic        rst;
    coord_t      hcount_in;
    coord_t      vcount_in;
    logic        hsync_in;
    logic        vsync_in;
    logic        hblnk_in;
    logic        vblnk_in;
    rgb_t        rgb_in;
    card_value_t card_value;
    card_suit_t  card_suit;
    coord_t      hcount_out;
    coord_t      vcount_out;
    logic        hsync_out;
    logic        vsync_out;
    logic        hblnk_out;
    logic        vblnk_out;
    rgb_t        rgb_out;

    glyph_t      model_glyphs [1:13];
    expect_t     expected_q [$];
    logic [31:0] lcg_state = 32'd35807;
    int          cycle_count = 0;
    int          checks = 0;
    int          rgb_errors = 0;
    int          timing_errors = 0;
    int          idle_errors = 0;
    int          other_errors = 0;
    int          ink_hits [1:13];
    int          red_hits = 0;
    int          black_hits = 0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) u_clk_gen (.clk, .rst);

    card_overlay_top uut (.*);

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state >> 16);    // low bits of an lcg cycle too fast
    endfunction

    function automatic logic [2:0] pixel_kind(input int h, input int v, input logic blank,
                                              input card_value_t value);
        int   gx;
        int   gy;
        logic in_rect;
        logic on_edge;
        gx = h - (`CARD_XPOS + `GLYPH_DX);
        gy = v - (`CARD_YPOS + `GLYPH_DY);
        in_rect = h >= `CARD_XPOS && h <= `CARD_XPOS + `CARD_W &&
                  v >= `CARD_YPOS && v <= `CARD_YPOS + `CARD_H;
        on_edge = h == `CARD_XPOS || h == `CARD_XPOS + `CARD_W ||
                  v == `CARD_YPOS || v == `CARD_YPOS + `CARD_H;
        if (blank)
            return K_BLANK;
        if (value < 1 || value > 13 || !in_rect)
            return K_PASS;
        if (on_edge)
            return K_BORDER;
        if (gx >= 0 && gx < `GLYPH_W && gy >= 0 && gy < `GLYPH_H &&
            model_glyphs[value][`GLYPH_W * `GLYPH_H - 1 - (gy * `GLYPH_W + gx)])
            return K_INK;
        return K_FACE;
    endfunction

    function automatic string kind_name(input logic [2:0] kind);
        case (kind)
            K_BORDER: return "card_border";
            K_FACE:   return "card_face";
            K_INK:    return "glyph_ink";
            K_BLANK:  return "blanking";
            default:  return "passthrough";
        endcase
    endfunction

    function automatic int mismatch(input string name, input logic [15:0] exp_v,
                                    input logic [15:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            $display("ERROR %s cycle %0d: expected %h, actual %h",
                     name, cycle_count, exp_v, act_v);
            return 1;
        end
        return 0;
    endfunction

    task automatic check_idle();
        idle_errors += mismatch("reset_idle hcount_out", 16'd0, hcount_out);
        idle_errors += mismatch("reset_idle vcount_out", 16'd0, vcount_out);
        idle_errors += mismatch("reset_idle hsync_out", 16'd0, hsync_out);
        idle_errors += mismatch("reset_idle vsync_out", 16'd0, vsync_out);
        idle_errors += mismatch("reset_idle hblnk_out", 16'd0, hblnk_out);
        idle_errors += mismatch("reset_idle vblnk_out", 16'd0, vblnk_out);
        idle_errors += mismatch("reset_idle rgb_out", 16'd0, rgb_out);
    endtask

    task automatic check_output(input expect_t e);
        rgb_errors    += mismatch(kind_name(e.kind), e.rgb, rgb_out);
        timing_errors += mismatch("timing hcount_out", e.hcount, hcount_out);
        timing_errors += mismatch("timing vcount_out", e.vcount, vcount_out);
        timing_errors += mismatch("timing hsync_out", e.hsync, hsync_out);
        timing_errors += mismatch("timing vsync_out", e.vsync, vsync_out);
        timing_errors += mismatch("timing hblnk_out", e.hblnk, hblnk_out);
        timing_errors += mismatch("timing vblnk_out", e.vblnk, vblnk_out);
    endtask

    // new card every segment, first sixteen segments walk every value once
    task automatic drive_pixel(input int n);
        expect_t e;
        int      h;
        int      v;
        int      sel;
        logic    blanked;
        if (n % SEGMENT == 0) begin
            if (n / SEGMENT < 16)
                card_value = card_value_t'(n / SEGMENT);
            else
                card_value = card_value_t'(next_rand() % 16);
            card_suit = card_suit_t'(next_rand() % 4);
        end
        if (next_rand() % 4 == 0) begin    // around the glyph box
            h = `CARD_XPOS + `GLYPH_DX - 1 + int'(next_rand() % (`GLYPH_W + 2));
            v = `CARD_YPOS + `GLYPH_DY - 1 + int'(next_rand() % (`GLYPH_H + 2));
        end else begin
            h = int'(next_rand() % 100);
            v = int'(next_rand() % 130);
        end
        blanked   = (next_rand() % 8 == 0);
        sel       = int'(next_rand() % 3);
        hcount_in = coord_t'(h);
        vcount_in = coord_t'(v);
        hblnk_in  = blanked && sel != 1;
        vblnk_in  = blanked && sel != 0;
        hsync_in  = (next_rand() % 2 != 0);
        vsync_in  = (next_rand() % 2 != 0);
        rgb_in    = rgb_t'(next_rand());

        e.hcount = hcount_in;
        e.vcount = vcount_in;
        e.hsync  = hsync_in;
        e.vsync  = vsync_in;
        e.hblnk  = hblnk_in;
        e.vblnk  = vblnk_in;
        e.kind   = pixel_kind(h, v, blanked, card_value);
        case (e.kind)
            K_BORDER: e.rgb = BORDER_BLACK;
            K_FACE:   e.rgb = FACE_WHITE;
            K_INK:    e.rgb = (card_suit >= SUIT_HEART) ? INK_RED : INK_BLACK;
            K_BLANK:  e.rgb = '0;
            default:  e.rgb = rgb_in;
        endcase
        if (e.kind == K_INK) begin
            ink_hits[card_value]++;
            if (card_suit >= SUIT_HEART)
                red_hits++;
            else
                black_hits++;
        end
        expected_q.push_back(e);
    endtask

    // ----------------------------------------------------------------------
    // run
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        expect_t e;
        int      n;
        hcount_in  = '0;
        vcount_in  = '0;
        hsync_in   = 1'b0;
        vsync_in   = 1'b0;
        hblnk_in   = 1'b0;
        vblnk_in   = 1'b0;
        rgb_in     = '0;
        card_value = '0;
        card_suit  = SUIT_SPADE;
        for (n = 1; n <= 13; n++)
            ink_hits[n] = 0;
        $readmemh("card_glyphs.mem", model_glyphs);
        for (n = 1; n <= 13; n++) begin
            if ($isunknown(model_glyphs[n])) begin
                $display("glyph bitmap for rank %0d missing from card_glyphs.mem", n);
                other_errors++;
            end
        end

        @(posedge clk);
        while (rst) begin
            #10;
            check_idle();
            @(posedge clk);
        end

        // compare against the pixel driven three edges back
        for (n = 0; n < N_STIM + LATENCY; n++) begin
            #10;
            if (n < LATENCY) begin
                check_idle();
            end else begin
                e = expected_q.pop_front();
                check_output(e);
            end
            if (n < N_STIM)
                drive_pixel(n);
            @(posedge clk);
        end

        for (n = 1; n <= 13; n++) begin
            if (ink_hits[n] == 0) begin
                $display("no glyph ink pixel of rank %0d was checked", n);
                other_errors++;
            end
        end
        if (red_hits == 0 || black_hits == 0) begin
            $display("glyph ink was not checked in both suit colours");
            other_errors++;
        end

        $display("checks %0d, rgb errors %0d, timing errors %0d, idle errors %0d, other errors %0d",
                 checks, rgb_errors, timing_errors, idle_errors, other_errors);
        if (rgb_errors + timing_errors + idle_errors + other_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== card_glyphs.mem ====
// one 72-bit rank bitmap per line for ranks 1 to 13 (A, 2..10, J, Q, K)
// nine rows of 8 pixels, row 0 in the top byte, leftmost pixel as the byte msb
182442427E42424200
3C4202040810207E00
3C42021C0202423C00
040C1424447E040400
7E40407C0202423C00
3C40407C4242423C00
7E0204081010101000
3C42423C4242423C00
3C4242423E02023C00
4CD252525252524C00
1E0404040444443800
3C424242424A443A00
424448704844424200

// ==== tb.f ====
+incdir+.
card_pkg.sv
vga_bus_if.sv
card_face_classifier.sv
vga_delay_line.sv
card_pixel_mixer.sv
card_overlay_top.sv
tb_clock_gen.sv
tb_card_overlay.sv

// ==== Bender.yml ====
package:
  name: card_overlay

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - card_pkg.sv
      - vga_bus_if.sv
      - card_face_classifier.sv
      - vga_delay_line.sv
      - card_pixel_mixer.sv
      - card_overlay_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_card_overlay.sv
